// File: build.f
+incdir+src
src/rxdp_csr_pkg.sv
src/rxdp_data_pkg.sv
src/rxdp_fifo_if.sv
src/rxdp_bitsync.sv
src/rxdp_word_align.sv
src/rxdp_async_fifo.sv
src/rxdp_phcomp_fifo.sv
src/rxdp_top.sv
tb/tb_rxdp_top.sv

// File: Bender.yml
package:
  name: rxdp

sources:
  - include_dirs:
      - src
    files:
      - src/rxdp_csr_pkg.sv
      - src/rxdp_data_pkg.sv
      - src/rxdp_fifo_if.sv
      - src/rxdp_bitsync.sv
      - src/rxdp_word_align.sv
      - src/rxdp_async_fifo.sv
      - src/rxdp_phcomp_fifo.sv
      - src/rxdp_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/tb_rxdp_top.sv

// File: tb/rxdp_input.txt
// Run count, then runs: wa_en mkbit delay empty pempty full pfull flagchk first_lane0
// flagchk bit4 enables flag checks, bits 3..0 are empty pempty full pfull
4
1 4f c 1 6 f 8 15 8a5c3e1f07b2d9468001
0 4f c 0 0 c b 1c 0a5c3e1f07b2d9468000
1 4f 3 2 4 f c 00 8a5c3e1f07b2d9468011
1 4f 7 2 4 f c 00 8a5c3e1f07b2d9468011
// Stream words, marker bit 79 on words 1, 5, 9, 13, 17
0a5c3e1f07b2d9468000
8a5c3e1f07b2d9468001
0a5c3e1f07b2d9468002
0a5c3e1f07b2d9468003
0a5c3e1f07b2d9468004
8a5c3e1f07b2d9468005
0a5c3e1f07b2d9468006
0a5c3e1f07b2d9468007
0a5c3e1f07b2d9468008
8a5c3e1f07b2d9468009
0a5c3e1f07b2d946800a
0a5c3e1f07b2d946800b
0a5c3e1f07b2d946800c
8a5c3e1f07b2d946800d
0a5c3e1f07b2d946800e
0a5c3e1f07b2d946800f
0a5c3e1f07b2d9468010
8a5c3e1f07b2d9468011
0a5c3e1f07b2d9468012
0a5c3e1f07b2d9468013

// File: tb/tb_rxdp_top.sv
// Testbench for rxdp_top with clocks, file reader, stream driver, compare tasks and timeout
`timescale 1ns/1ns
`default_nettype none

`include "rxdp_cfg.svh"

module tb_rxdp_top;
   import rxdp_csr_pkg::*;
   import rxdp_data_pkg::*;

   localparam int SLEN   = 20;            // Input stream words before wrap
   localparam int FWORDS = 57;            // Tokens in the input file
   localparam int NOUT   = 12;            // Output words checked per run
   localparam int TLIMIT = SLEN + 64;     // Read cycles allowed per run

   logic                                wr_clk = 1'b0;
   logic                                rd_clk = 1'b0;
   logic                                wr_rst_n;
   logic                                rd_rst_n;
   link_word_t                          fifo_din;
   logic                                r_wa_en;
   mkbit_t                              r_mkbit;
   rd_delay_t                           r_phcomp_rd_delay;
   thresh_t                             r_empty;
   thresh_t                             r_pempty;
   thresh_t                             r_full;
   thresh_t                             r_pfull;
   logic [`RXDP_LANES*`RXDP_DWIDTH-1:0] fifo_dout;
   logic                                fifo_empty;
   logic                                fifo_pempty;
   logic                                fifo_full;
   logic                                fifo_pfull;
   logic                                align_done;

   link_word_t fdat [0:FWORDS-1];   // Run lines then stream words
   int         sbase;               // First stream word in fdat
   int         sidx;                // Stream position being driven
   logic       streaming = 1'b0;

   rxdp_top u_rxdp_top (
      .wr_clk (wr_clk), .wr_rst_n (wr_rst_n), .rd_clk (rd_clk), .rd_rst_n (rd_rst_n),
      .fifo_din (fifo_din), .r_wa_en (r_wa_en), .r_mkbit (r_mkbit),
      .r_phcomp_rd_delay (r_phcomp_rd_delay), .r_empty (r_empty), .r_pempty (r_pempty),
      .r_full (r_full), .r_pfull (r_pfull), .fifo_dout (fifo_dout),
      .fifo_empty (fifo_empty), .fifo_pempty (fifo_pempty), .fifo_full (fifo_full),
      .fifo_pfull (fifo_pfull), .align_done (align_done)
   );

   //****************************************
   // Clocks with rises lining up every 100 ns
   //****************************************
   always begin
      #12 wr_clk = 1'b0;    // 25 ns period on a 1 ns grid
      #13 wr_clk = 1'b1;
   end

   always begin
      #50 rd_clk = 1'b1;
      #50 rd_clk = 1'b0;
   end

   // Next stream word 5 ns after each write edge
   always @(posedge wr_clk) begin
      if (streaming) begin
         #5;
         sidx     = sidx + 1;
         fifo_din = sword(sidx);
      end
   end

   function automatic link_word_t sword(input int j);
      return fdat[sbase + (j % SLEN)];   // Stream wraps
   endfunction

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("CHECKS FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_word(input string name, input link_word_t got, input link_word_t exp);
      if (got !== exp) begin
         stop_with_error($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stop_with_error($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
      end
   endtask

   task automatic step_rd();
      @(posedge rd_clk);
      #5;                     // Registered outputs settled
   endtask

   //****************************************
   // One run from one file line
   //****************************************
   task automatic run_one(input int r);
      int         f;
      int         cycles;
      int         idx;
      int         found;
      logic [4:0] fchk;          // Flag check enable and expected flags
      link_word_t exp_first;
      rd_word_u   rw;
      f = 1 + 9 * r;
      step_rd();
      streaming         = 1'b0;
      wr_rst_n          = 1'b0;
      rd_rst_n          = 1'b0;
      fifo_din          = '0;
      r_wa_en           = fdat[f][0];
      r_mkbit           = mkbit_t'(fdat[f+1]);
      r_phcomp_rd_delay = rd_delay_t'(fdat[f+2]);
      r_empty           = thresh_t'(fdat[f+3]);
      r_pempty          = thresh_t'(fdat[f+4]);
      r_full            = thresh_t'(fdat[f+5]);
      r_pfull           = thresh_t'(fdat[f+6]);
      fchk              = fdat[f+7][4:0];
      exp_first         = fdat[f+8];
      for (int c = 0; c < 8; c++) begin    // Reset values
         step_rd();
         rw.flat = fifo_dout;
         for (int l = 0; l < `RXDP_LANES; l++) begin
            check_word($sformatf("fifo_dout lane %0d in reset", l), rw.lane[l], '0);
         end
         check_flag("fifo_full in reset", fifo_full, 1'b0);
         check_flag("fifo_pfull in reset", fifo_pfull, 1'b0);
         check_flag("fifo_empty in reset", fifo_empty, 1'b1);
         check_flag("align_done in reset", align_done, 1'b0);
      end
      wr_rst_n  = 1'b1;
      rd_rst_n  = 1'b1;
      sidx      = 0;
      fifo_din  = sword(0);
      streaming = 1'b1;
      cycles    = 0;
      while (!align_done) begin
         step_rd();
         cycles++;
         if (cycles > TLIMIT) begin
            stop_with_error($sformatf("Run %0d timed out, align_done never came", r));
         end
         rw.flat = fifo_dout;
         if (!align_done) begin
            for (int l = 0; l < `RXDP_LANES; l++) begin
               check_word("fifo_dout before align_done", rw.lane[l], '0);
            end
         end
      end
      for (int ow = 0; ow < NOUT; ow++) begin
         if (ow > 0) begin
            step_rd();
            cycles++;
         end
         if (cycles > TLIMIT) begin
            stop_with_error($sformatf("Run %0d timed out while reading output words", r));
         end
         rw.flat = fifo_dout;
         check_flag("align_done", align_done, 1'b1);
         if (ow == 0) begin           // Find where the output starts
            found = -1;
            for (int j = 0; j < SLEN; j++) begin
               if (found < 0 && sword(j) === rw.lane[0]) found = j;
            end
            if (found < 0) stop_with_error("First output lane 0 is not a word of the stream");
            check_word("first fifo_dout lane 0", rw.lane[0], exp_first);
            idx = found;
         end
         for (int l = 0; l < `RXDP_LANES; l++) begin
            check_word($sformatf("fifo_dout lane %0d", l), rw.lane[l], sword(idx + l));
            if (r_wa_en) begin
               check_flag($sformatf("fifo_dout lane %0d marker bit", l),
                          rw.lane[l][r_mkbit], l == 0);
            end
         end
         idx += `RXDP_LANES;
         if (fchk[4] && ow >= 3) begin    // Steady state only
            check_flag("fifo_empty", fifo_empty, fchk[3]);
            check_flag("fifo_pempty", fifo_pempty, fchk[2]);
            check_flag("fifo_full", fifo_full, fchk[1]);
            check_flag("fifo_pfull", fifo_pfull, fchk[0]);
         end
      end
      streaming = 1'b0;
   endtask

   initial begin
      wr_rst_n          = 1'b0;
      rd_rst_n          = 1'b0;
      fifo_din          = '0;
      r_wa_en           = 1'b0;
      r_mkbit           = '0;
      r_phcomp_rd_delay = '0;
      r_empty           = '0;
      r_pempty          = '0;
      r_full            = '0;
      r_pfull           = '0;
      $readmemh("tb/rxdp_input.txt", fdat);
      sbase = 1 + 9 * int'(fdat[0]);
      if (sbase + SLEN != FWORDS) begin
         stop_with_error("Input file run count does not match its length");
      end
      for (int r = 0; r < int'(fdat[0]); r++) begin
         run_one(r);
      end
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: src/rxdp_top.sv
// Receive datapath adapter top with word aligner and phase-comp FIFO
`timescale 1ns/1ns
`default_nettype none

`include "rxdp_cfg.svh"

module rxdp_top (
   input  logic                                wr_clk,            // Link word clock
   input  logic                                wr_rst_n,
   input  logic                                rd_clk,            // Quarter rate clock
   input  logic                                rd_rst_n,
   input  rxdp_data_pkg::link_word_t           fifo_din,
   input  logic                                r_wa_en,
   input  rxdp_csr_pkg::mkbit_t                r_mkbit,
   input  rxdp_csr_pkg::rd_delay_t             r_phcomp_rd_delay,
   input  rxdp_csr_pkg::thresh_t               r_empty,
   input  rxdp_csr_pkg::thresh_t               r_pempty,
   input  rxdp_csr_pkg::thresh_t               r_full,
   input  rxdp_csr_pkg::thresh_t               r_pfull,
   output logic [`RXDP_LANES*`RXDP_DWIDTH-1:0] fifo_dout,         // Lane 0 in low bits
   output logic                                fifo_empty,
   output logic                                fifo_pempty,
   output logic                                fifo_full,
   output logic                                fifo_pfull,
   output logic                                align_done
);

   logic wa_lock;   // Marker lock, write domain

   rxdp_word_align u_word_align (
      .wr_clk   (wr_clk),
      .wr_rst_n (wr_rst_n),
      .fifo_din (fifo_din),
      .r_wa_en  (r_wa_en),
      .r_mkbit  (r_mkbit),
      .wa_lock  (wa_lock)
   );

   rxdp_phcomp_fifo u_phcomp_fifo (
      .wr_clk            (wr_clk),
      .wr_rst_n          (wr_rst_n),
      .rd_clk            (rd_clk),
      .rd_rst_n          (rd_rst_n),
      .fifo_din          (fifo_din),
      .wa_lock           (wa_lock),
      .r_wa_en           (r_wa_en),
      .r_phcomp_rd_delay (r_phcomp_rd_delay),
      .r_empty           (r_empty),
      .r_pempty          (r_pempty),
      .r_full            (r_full),
      .r_pfull           (r_pfull),
      .fifo_dout         (fifo_dout),
      .fifo_empty        (fifo_empty),
      .fifo_pempty       (fifo_pempty),
      .fifo_full         (fifo_full),
      .fifo_pfull        (fifo_pfull),
      .align_done        (align_done)
   );

endmodule

`default_nettype wire

// File: src/rxdp_phcomp_fifo.sv
// Phase-comp controller with write start pipeline, read delay taps and output register
`timescale 1ns/1ns
`default_nettype none

`include "rxdp_cfg.svh"

module rxdp_phcomp_fifo (
   input  logic                              wr_clk,
   input  logic                              wr_rst_n,
   input  logic                              rd_clk,
   input  logic                              rd_rst_n,
   input  rxdp_data_pkg::link_word_t         fifo_din,
   input  logic                              wa_lock,           // From word aligner
   input  logic                              r_wa_en,
   input  rxdp_csr_pkg::rd_delay_t           r_phcomp_rd_delay, // Pointer gap code
   input  rxdp_csr_pkg::thresh_t             r_empty,
   input  rxdp_csr_pkg::thresh_t             r_pempty,
   input  rxdp_csr_pkg::thresh_t             r_full,
   input  rxdp_csr_pkg::thresh_t             r_pfull,
   output logic [`RXDP_LANES*`RXDP_DWIDTH-1:0] fifo_dout,
   output logic                              fifo_empty,
   output logic                              fifo_pempty,
   output logic                              fifo_full,
   output logic                              fifo_pfull,
   output logic                              align_done         // First valid output
);
   import rxdp_csr_pkg::*;
   import rxdp_data_pkg::*;

   rxdp_fifo_if fifo_bus ();

   logic       phcomp_wren_d0;     // Sticky write start
   logic       phcomp_wren_d1;
   logic       phcomp_wren_d2;
   link_word_t din_d0;             // Data rides with the flag
   link_word_t din_d1;
   link_word_t din_d2;
   logic       phcomp_wren_sync2;
   logic       phcomp_wren_sync3;
   logic       phcomp_wren_sync4;
   logic       phcomp_wren_sync5;
   logic       phcomp_wren_sync6;
   logic       phcomp_wren_sync7;
   rd_delay_t  rd_delay_mod;       // Clamped delay code
   logic       phcomp_rden;
   rd_word_u   data_out;

   //****************************************
   // Write start, wr_clk
   //****************************************
   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         phcomp_wren_d0 <= 1'b0;
         phcomp_wren_d1 <= 1'b0;
         phcomp_wren_d2 <= 1'b0;
      end else begin
         phcomp_wren_d0 <= ~r_wa_en | wa_lock | phcomp_wren_d0;
         phcomp_wren_d1 <= phcomp_wren_d0;
         phcomp_wren_d2 <= phcomp_wren_d1;
      end
   end

   always_ff @(posedge wr_clk) begin
      din_d0 <= fifo_din;     // Marker word lands with first enable
      din_d1 <= din_d0;
      din_d2 <= din_d1;
   end

   assign fifo_bus.wr_en   = phcomp_wren_d2;
   assign fifo_bus.wr_data = din_d2;

   //****************************************
   // Read start, rd_clk
   //****************************************
   rxdp_bitsync u_wren_sync (
      .clk      (rd_clk),
      .rst_n    (rd_rst_n),
      .data_in  (phcomp_wren_d2),
      .data_out (phcomp_wren_sync2)
   );

   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         phcomp_wren_sync3 <= 1'b0;
         phcomp_wren_sync4 <= 1'b0;
         phcomp_wren_sync5 <= 1'b0;
         phcomp_wren_sync6 <= 1'b0;
         phcomp_wren_sync7 <= 1'b0;
      end else begin
         phcomp_wren_sync3 <= phcomp_wren_sync2;
         phcomp_wren_sync4 <= phcomp_wren_sync3;
         phcomp_wren_sync5 <= phcomp_wren_sync4;
         phcomp_wren_sync6 <= phcomp_wren_sync5;
         phcomp_wren_sync7 <= phcomp_wren_sync6;
      end
   end

   // Quarter rate needs at least six stages of gap
   assign rd_delay_mod = (r_phcomp_rd_delay < 4'd6) ? 4'd6 : r_phcomp_rd_delay;

   always_comb begin
      case (rd_delay_mod)
         4'd7:    phcomp_rden = phcomp_wren_sync7;
         4'd6:    phcomp_rden = phcomp_wren_sync6;
         default: phcomp_rden = phcomp_wren_sync2;   // Codes 8 to 15
      endcase
   end

   assign fifo_bus.rd_en = phcomp_rden;

   //****************************************
   // Output register
   //****************************************
   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         data_out   <= '0;
         align_done <= 1'b0;
      end else begin
         data_out   <= phcomp_rden ? fifo_bus.rd_data : '0;   // Zero when idle
         align_done <= phcomp_rden;
      end
   end

   assign fifo_dout   = data_out.flat;
   assign fifo_empty  = fifo_bus.empty;
   assign fifo_pempty = fifo_bus.pempty;
   assign fifo_full   = fifo_bus.full;
   assign fifo_pfull  = fifo_bus.pfull;

   rxdp_async_fifo u_async_fifo (
      .wr_clk   (wr_clk),
      .wr_rst_n (wr_rst_n),
      .rd_clk   (rd_clk),
      .rd_rst_n (rd_rst_n),
      .r_empty  (r_empty),
      .r_pempty (r_pempty),
      .r_full   (r_full),
      .r_pfull  (r_pfull),
      .fifo     (fifo_bus.mem)
   );

endmodule

`default_nettype wire

// File: src/rxdp_async_fifo.sv
// Dual-clock FIFO with Gray pointers, four-word read pop and level flags
`timescale 1ns/1ns
`default_nettype none

`include "rxdp_cfg.svh"

module rxdp_async_fifo (
   input  logic                  wr_clk,     // Write clock, full rate
   input  logic                  wr_rst_n,   // Write reset, active low
   input  logic                  rd_clk,     // Read clock, quarter rate
   input  logic                  rd_rst_n,   // Read reset, active low
   input  rxdp_csr_pkg::thresh_t r_empty,    // Empty level
   input  rxdp_csr_pkg::thresh_t r_pempty,   // Partial empty level
   input  rxdp_csr_pkg::thresh_t r_full,     // Full level
   input  rxdp_csr_pkg::thresh_t r_pfull,    // Partial full level
   rxdp_fifo_if.mem              fifo        // Controller side
);
   import rxdp_data_pkg::*;

   localparam int DEPTH = 1 << `RXDP_AWIDTH;
   localparam int LSEL  = $clog2(`RXDP_LANES);   // Lane select address bits

   link_word_t mem [DEPTH];    // Storage, no reset

   fill_t    wr_ptr;           // Binary, steps by one
   fill_t    wr_gray;          // Gray copy for read side
   fill_t    wr_gray_s1;
   fill_t    wr_gray_s2;
   fill_t    rd_ptr;           // Binary, steps by four
   fill_t    rd_gray;          // Gray of rd_ptr upper bits
   fill_t    rd_gray_s1;
   fill_t    rd_gray_s2;
   fill_t    wr_ptr_rd;        // Write pointer in read domain
   fill_t    rd_ptr_wr;        // Read pointer in write domain
   fill_t    rd_fill;
   fill_t    wr_fill;
   rd_word_u pop_word;
   logic     empty_q;
   logic     pempty_q;
   logic     full_q;
   logic     pfull_q;

   function automatic fill_t bin2gray(fill_t bin);
      return bin ^ (bin >> 1);
   endfunction

   function automatic fill_t gray2bin(fill_t gray);
      fill_t bin;
      bin[`RXDP_AWIDTH] = gray[`RXDP_AWIDTH];
      for (int i = `RXDP_AWIDTH - 1; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

   //****************************************
   // Write domain
   //****************************************
   always_ff @(posedge wr_clk) begin
      if (fifo.wr_en) begin
         mem[wr_ptr[`RXDP_AWIDTH-1:0]] <= fifo.wr_data;
      end
   end

   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         wr_ptr     <= '0;
         wr_gray    <= '0;
         rd_gray_s1 <= '0;
         rd_gray_s2 <= '0;
         full_q     <= 1'b0;
         pfull_q    <= 1'b0;
      end else begin
         if (fifo.wr_en) begin
            wr_ptr  <= wr_ptr + fill_t'(1);
            wr_gray <= bin2gray(wr_ptr + fill_t'(1));
         end
         rd_gray_s1 <= rd_gray;                     // Cross from rd_clk
         rd_gray_s2 <= rd_gray_s1;
         full_q     <= wr_fill >= {1'b0, r_full};   // Report only
         pfull_q    <= wr_fill >= {1'b0, r_pfull};
      end
   end

   assign rd_ptr_wr = gray2bin(rd_gray_s2) << LSEL;   // Low bits always zero
   assign wr_fill   = wr_ptr - rd_ptr_wr;

   //****************************************
   // Read domain
   //****************************************
   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         rd_ptr     <= '0;
         rd_gray    <= '0;
         wr_gray_s1 <= '0;
         wr_gray_s2 <= '0;
         empty_q    <= 1'b1;
         pempty_q   <= 1'b1;
      end else begin
         if (fifo.rd_en) begin
            rd_ptr  <= rd_ptr + fill_t'(`RXDP_LANES);
            // One bit changes per pop
            rd_gray <= bin2gray((rd_ptr + fill_t'(`RXDP_LANES)) >> LSEL);
         end
         wr_gray_s1 <= wr_gray;                      // Cross from wr_clk
         wr_gray_s2 <= wr_gray_s1;
         empty_q    <= rd_fill <= {1'b0, r_empty};
         pempty_q   <= rd_fill <= {1'b0, r_pempty};
      end
   end

   assign wr_ptr_rd = gray2bin(wr_gray_s2);
   assign rd_fill   = wr_ptr_rd - rd_ptr;

   // Four consecutive words, oldest in lane 0
   always_comb begin
      for (int i = 0; i < `RXDP_LANES; i++) begin
         pop_word.lane[i] = mem[{rd_ptr[`RXDP_AWIDTH-1:LSEL], i[LSEL-1:0]}];
      end
   end

   assign fifo.rd_data = pop_word;
   assign fifo.empty   = empty_q;
   assign fifo.pempty  = pempty_q;
   assign fifo.full    = full_q;
   assign fifo.pfull   = pfull_q;

endmodule

`default_nettype wire

// File: src/rxdp_word_align.sv
// Write-domain marker bit detector with sticky word-align lock
`timescale 1ns/1ns
`default_nettype none

`include "rxdp_cfg.svh"

module rxdp_word_align (
   input  logic                     wr_clk,     // Write clock
   input  logic                     wr_rst_n,   // Write reset, active low
   input  rxdp_data_pkg::link_word_t fifo_din,  // Incoming link word
   input  logic                     r_wa_en,    // Word align enable
   input  rxdp_csr_pkg::mkbit_t     r_mkbit,    // Marker bit position
   output logic                     wa_lock     // High from marker word on
);

   logic mk_hit;     // Marker seen on the current word
   logic lock_q;     // Sticky lock

   //****************************************
   // Marker detect
   //****************************************

   // Index past the word never matches
   assign mk_hit = r_wa_en && (r_mkbit < `RXDP_DWIDTH) && fifo_din[r_mkbit];

   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         lock_q <= 1'b0;
      end else begin
         lock_q <= lock_q | mk_hit;   // Held until reset
      end
   end

   // Same cycle as the marker word
   assign wa_lock = mk_hit | lock_q;

endmodule

`default_nettype wire

// File: src/rxdp_bitsync.sv
// Two-flop synchronizer for one control bit into a destination clock
`timescale 1ns/1ns
`default_nettype none

module rxdp_bitsync (
   input  logic clk,        // Destination clock
   input  logic rst_n,      // Sync reset, active low
   input  logic data_in,    // Async level from other domain
   output logic data_out    // Synchronized level
);

   logic sync_s1;   // First stage, may go metastable

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sync_s1  <= 1'b0;
         data_out <= 1'b0;
      end else begin
         sync_s1  <= data_in;
         data_out <= sync_s1;    // Settled copy
      end
   end

endmodule

`default_nettype wire

// File: src/rxdp_fifo_if.sv
// Interface between the phase-comp controller and the async FIFO with modports
`timescale 1ns/1ns
`default_nettype none

interface rxdp_fifo_if;
   import rxdp_data_pkg::*;

   logic       wr_en;      // Store one word, wr_clk
   link_word_t wr_data;    // Word to store
   logic       rd_en;      // Pop four words, rd_clk
   rd_word_u   rd_data;    // Four popped words
   logic       empty;      // Read domain
   logic       pempty;     // Read domain
   logic       full;       // Write domain
   logic       pfull;      // Write domain

   modport ctrl (output wr_en, wr_data, rd_en,
                 input  rd_data, empty, pempty, full, pfull);

   modport mem  (input  wr_en, wr_data, rd_en,
                 output rd_data, empty, pempty, full, pfull);

endinterface

`default_nettype wire

// File: src/rxdp_data_pkg.sv
// Datapath types for link words, the four-lane read word and fill counts
`default_nettype none

`include "rxdp_cfg.svh"

package rxdp_data_pkg;

   typedef logic [`RXDP_DWIDTH-1:0] link_word_t;   // One write-side word

   // Read word, flat for the output port, lanes for the FIFO pop
   typedef union packed {
      logic [`RXDP_LANES*`RXDP_DWIDTH-1:0] flat;
      link_word_t [`RXDP_LANES-1:0]        lane;  // Lane 0 is oldest
   } rd_word_u;

   typedef logic [`RXDP_AWIDTH:0] fill_t;  // Pointer or fill, one wrap bit

endpackage

`default_nettype wire

// File: src/rxdp_csr_pkg.sv
// Configuration register types for thresholds, read delay and marker index
`default_nettype none

`include "rxdp_cfg.svh"

package rxdp_csr_pkg;

   // FIFO level threshold, compared against fill counts
   typedef logic [`RXDP_AWIDTH-1:0] thresh_t;

   typedef logic [3:0] rd_delay_t;    // Read start delay code
   typedef logic [6:0] mkbit_t;       // Marker bit index in a word

endpackage

`default_nettype wire

// File: src/rxdp_cfg.svh
// Link word width, FIFO address width and read lane count macros
`ifndef RXDP_CFG_SVH
`define RXDP_CFG_SVH

`define RXDP_DWIDTH 80      // Bits per link word
`define RXDP_AWIDTH 4       // FIFO address bits, 16 words deep
`define RXDP_LANES  4       // Words popped per read clock, quarter rate

`endif
